// File: Bender.yml
package:
  name: jacobian_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/arm_pkg.sv
      - verilog/sched_pkg.sv
      - verilog/joint_capture.sv
      - verilog/jacobian_sequencer.sv
      - verilog/sincos_unit.sv
      - verilog/jacobian_mac.sv
      - verilog/jacobian_out.sv
      - verilog/jacobian_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/jacobian_sva.sv
      - verification/jacobian_tb.sv

// File: src.f
+incdir+verilog
verilog/arm_pkg.sv
verilog/sched_pkg.sv
verilog/joint_capture.sv
verilog/jacobian_sequencer.sv
verilog/sincos_unit.sv
verilog/jacobian_mac.sv
verilog/jacobian_out.sv
verilog/jacobian_top.sv
verification/jacobian_sva.sv
verification/jacobian_tb.sv

// File: verification/jacobian_sva.sv
// assertions on the output stage for frame_done pulse shape and output stability

`default_nettype none

module jacobian_sva import arm_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic frame_done,
	input fix_t j11,
	input fix_t j12,
	input fix_t j21,
	input fix_t j22
);

	int fail_count = 0;                           // failed assertions so far

	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |=> !frame_done)
		else begin
			$error("frame_done high in two consecutive cycles");
			fail_count = fail_count + 1;
		end

	// outputs only move in the cycle that carries the pulse
	a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable({j11, j12, j21, j22}) |-> frame_done)
		else begin
			$error("outputs changed without frame_done");
			fail_count = fail_count + 1;
		end

	a_reset_low: assert property (@(posedge clk) !rst_n |-> !frame_done)
		else begin
			$error("frame_done high during reset");
			fail_count = fail_count + 1;
		end

endmodule

bind jacobian_out jacobian_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.frame_done (frame_done),
	.j11        (j11),
	.j12        (j12),
	.j21        (j21),
	.j22        (j22)
);

`default_nettype wire

// File: verification/jacobian_tb.sv
// testbench for the two-link arm Jacobian engine
// drives random and boundary angles and compares each frame with a reference model

`default_nettype none

module jacobian_tb import arm_pkg::*, sched_pkg::*; ();

	`include "sine_table.svh"

	logic   clk;
	logic   rst_n;
	logic   en;
	angle_t theta1;
	angle_t theta2;
	fix_t   j11;
	fix_t   j12;
	fix_t   j21;
	fix_t   j22;
	logic   frame_done;

	integer seed;
	int     cyc = 0;                              // clock edges seen
	int     en_edges = 0;                         // enabled edges seen
	int     tb_count = 0;
	int     cap_count = 0;
	int     frames_checked = 0;
	int     last_done = -1;
	logic   cont = 1'b0;                          // set while en is held high and timing is fixed
	int     cap_t1[$];
	int     cap_t2[$];
	int     cap_edge[$];
	int     cap_cyc[$];
	int     edge_vals[5] = '{0, 1024, 2048, 3072, 4095};

	jacobian_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.theta1     (theta1),
		.theta2     (theta2),
		.j11        (j11),
		.j12        (j12),
		.j21        (j21),
		.j22        (j22),
		.frame_done (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		if (exp_v !== got_v) begin
			$display("ERR %s expected %h got %h", name, exp_v, got_v);
			abort_run();
		end
	endtask

	// quadrant from bits 11:10 and table step from bits 9:5
	function automatic int table_sine(input int a);
		int p;
		p = (a >> 5) & 31;
		case ((a >> 10) & 3)
			0:       return SINE_TABLE[p];
			1:       return SINE_TABLE[32 - p];
			2:       return -SINE_TABLE[p];
			default: return -SINE_TABLE[32 - p];
		endcase
	endfunction

	function automatic void expected_entries(input int t1, input int t2,
		output fix_t e11, output fix_t e12, output fix_t e21, output fix_t e22);
		int a1;
		int a12;
		int ps1;
		int ps12;
		int pc1;
		int pc12;
		a1   = (t1 - int'(JOINT1_OFFSET)) & 4095;
		a12  = (a1 + t2 - int'(JOINT2_OFFSET)) & 4095;
		ps1  = (int'(L1) * table_sine(a1)) >>> FRAC_BITS;
		ps12 = (int'(L2) * table_sine(a12)) >>> FRAC_BITS;
		pc1  = (int'(L1) * table_sine((a1 + 1024) & 4095)) >>> FRAC_BITS; // cos is sin shifted
		pc12 = (int'(L2) * table_sine((a12 + 1024) & 4095)) >>> FRAC_BITS;
		e11  = fix_t'(-(ps1 + ps12));
		e12  = fix_t'(-ps12);
		e21  = fix_t'(pc1 + pc12);
		e22  = fix_t'(pc12);
	endfunction

	// own copy of the frame count records the angles at each capture edge
	always @(posedge clk) begin
		if (rst_n && en) begin
			if (tb_count == 0) begin
				cap_t1.push_back(theta1);
				cap_t2.push_back(theta2);
				cap_edge.push_back(en_edges);
				cap_cyc.push_back(cyc);
				cap_count = cap_count + 1;
			end
			tb_count = (tb_count == FRAME_LEN - 1) ? 0 : tb_count + 1;
			en_edges = en_edges + 1;
		end
		cyc = cyc + 1;
	end

	always @(negedge clk) begin
		if (uut.u_out.u_sva.fail_count != 0) begin
			$display("an output stage assertion failed");
			abort_run();
		end
	end

	initial begin : compare_frames
		int   waited;
		int   t_cap;
		fix_t e11;
		fix_t e12;
		fix_t e21;
		fix_t e22;
		forever begin
			waited = 0;
			@(negedge clk);
			while (frame_done !== 1'b1) begin
				if (frames_checked == 0) begin        // reset values until first publish
					check_val("j11", 0, j11);
					check_val("j12", 0, j12);
					check_val("j21", 0, j21);
					check_val("j22", 0, j22);
				end
				waited = waited + 1;
				if (waited > 400) begin
					$display("timeout while waiting for frame_done");
					abort_run();
				end
				@(negedge clk);
			end
			if (cap_t1.size() == 0) begin
				$display("frame_done pulsed with no captured frame pending");
				abort_run();
			end
			expected_entries(cap_t1.pop_front(), cap_t2.pop_front(), e11, e12, e21, e22);
			check_val("j11", e11, j11);
			check_val("j12", e12, j12);
			check_val("j21", e21, j21);
			check_val("j22", e22, j22);
			check_val("latency_en_cycles", 10, en_edges - cap_edge.pop_front());
			t_cap = cap_cyc.pop_front();
			if (cont) begin
				check_val("latency_clocks", 10, cyc - t_cap);
				if (last_done >= 0)
					check_val("frame_period", 12, cyc - last_done);
			end
			last_done = cyc;
			frames_checked = frames_checked + 1;
		end
	end

	// mode 0 continuous, 1 boundary angles, 2 random enable, 3 sweep
	task automatic run_frames(input int n, input int mode);
		int target;
		int base;
		int waited;
		int idx;
		target = frames_checked + n;
		base   = cap_count;
		waited = 0;
		while (frames_checked < target) begin
			@(posedge clk);
			#2;
			idx = cap_count - base;
			en  = (mode == 2) ? (($random(seed) & 3) != 0) : 1'b1;
			if (mode == 1) begin                      // held for a whole frame
				theta1 = angle_t'((edge_vals[idx % 5] + JOINT1_OFFSET) & 4095);
				theta2 = angle_t'((edge_vals[(idx / 5) % 5] + JOINT2_OFFSET) & 4095);
			end else begin
				theta1 = angle_t'($random(seed));
				theta2 = angle_t'($random(seed));
			end
			waited = waited + 1;
			if (waited > 40 * n + 100) begin
				$display("timeout, %0d frames were never published", target - frames_checked);
				abort_run();
			end
		end
	endtask

	initial begin : stimulus
		seed   = 45356;
		rst_n  = 1'b0;
		en     = 1'b0;
		theta1 = '0;
		theta2 = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		cont  = 1'b1;
		run_frames(6, 0);
		cont = 1'b0;
		run_frames(25, 1);                            // quadrant edges and theta12 wrap
		run_frames(20, 2);
		run_frames(200, 3);
		if (uut.u_out.u_sva.fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("an output stage assertion failed");
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: verilog/arm_pkg.sv
// arm geometry and number formats for the two-link Jacobian engine
// angles are raw encoder counts, trig and lengths are Q1.14

`default_nettype none

package arm_pkg;

	typedef logic [11:0] angle_t;          // 4096 counts per turn
	typedef logic signed [15:0] fix_t;     // Q1.14
	typedef logic signed [17:0] acc_t;     // headroom for L1*s1 + L2*s12

	localparam int FRAC_BITS = 14;
	localparam int TABLE_STEPS = 32;       // table steps per quarter turn

	// link lengths, sum stays below 2.0 so nothing overflows
	localparam fix_t L1 = 16'sd12288;      // 0.75
	localparam fix_t L2 = 16'sd8192;       // 0.5

	// encoder reading at the mechanical zero of each joint
	localparam angle_t JOINT1_OFFSET = 12'd100;
	localparam angle_t JOINT2_OFFSET = 12'd3900;

endpackage

`default_nettype wire

// File: verilog/jacobian_mac.sv
// shared multiplier-accumulator, one link-length product per enabled cycle
// builds the four Jacobian entries in scratch registers

`default_nettype none

module jacobian_mac import arm_pkg::*, sched_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	input  op_e  op,
	input  fix_t s1,
	input  fix_t c1,
	input  fix_t s12,
	input  fix_t c12,
	output fix_t acc_j11,
	output fix_t acc_j12,
	output fix_t acc_j21,
	output fix_t acc_j22
);

	fix_t               coef;
	fix_t               operand;
	logic signed [31:0] prod;
	acc_t               prod_s;
	acc_t               sum;
	acc_t               acc;

	// operand select, L1 goes with theta1 terms and L2 with theta12 terms
	always_comb begin
		case (op)
			OP_MUL_S1: begin
				coef    = L1;
				operand = s1;
			end
			OP_MAC_S12, OP_MUL_S12: begin
				coef    = L2;
				operand = s12;
			end
			OP_MUL_C1: begin
				coef    = L1;
				operand = c1;
			end
			OP_MAC_C12, OP_MUL_C12: begin
				coef    = L2;
				operand = c12;
			end
			default: begin
				coef    = L1;
				operand = '0;
			end
		endcase
	end

	assign prod   = coef * operand;
	assign prod_s = acc_t'(prod >>> FRAC_BITS);      // back to Q1.14
	assign sum    = acc + prod_s;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			acc_j11 <= '0;
			acc_j12 <= '0;
			acc_j21 <= '0;
			acc_j22 <= '0;
		end else if (en) begin
			case (op)
				OP_MUL_S1, OP_MUL_C1: acc <= prod_s;
				OP_MAC_S12: begin
					acc     <= sum;
					acc_j11 <= fix_t'(-sum);         // -(L1*s1 + L2*s12)
				end
				OP_MUL_S12: begin
					acc     <= prod_s;
					acc_j12 <= fix_t'(-prod_s);
				end
				OP_MAC_C12: begin
					acc     <= sum;
					acc_j21 <= fix_t'(sum);
				end
				OP_MUL_C12: begin
					acc     <= prod_s;
					acc_j22 <= fix_t'(prod_s);
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/jacobian_out.sv
// output stage, publishes all four entries at once
// outputs hold while the next frame rewrites the scratch registers

`default_nettype none

module jacobian_out import arm_pkg::*, sched_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	input  op_e  op,
	input  fix_t acc_j11,
	input  fix_t acc_j12,
	input  fix_t acc_j21,
	input  fix_t acc_j22,
	output fix_t j11,
	output fix_t j12,
	output fix_t j21,
	output fix_t j22,
	output logic frame_done
);

	logic publish;

	assign publish = en && op == OP_PUBLISH;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			j11        <= '0;
			j12        <= '0;
			j21        <= '0;
			j22        <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= publish;                   // one clock, low while en is low
			if (publish) begin
				j11 <= acc_j11;
				j12 <= acc_j12;
				j21 <= acc_j21;
				j22 <= acc_j22;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/jacobian_sequencer.sv
// frame sequencer, counts enabled cycles and decodes the count
// into the opcode that steers every datapath block

`default_nettype none

module jacobian_sequencer import sched_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	output op_e  op
);

	count_t count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (en) begin
			if (count == count_t'(FRAME_LEN - 1)) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// fixed schedule, the multiplier is busy from count 3 to 8
	always_comb begin
		case (count)
			4'd0:    op = OP_CAPTURE;
			4'd1:    op = OP_TRIG1;
			4'd2:    op = OP_TRIG12;
			4'd3:    op = OP_MUL_S1;
			4'd4:    op = OP_MAC_S12;
			4'd5:    op = OP_MUL_S12;
			4'd6:    op = OP_MUL_C1;
			4'd7:    op = OP_MAC_C12;
			4'd8:    op = OP_MUL_C12;
			4'd9:    op = OP_PUBLISH;
			default: op = OP_IDLE;                   // counts 10 and 11
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/jacobian_top.sv
// two-link arm Jacobian engine, top level
// sequencer, capture, trig, shared MAC and output stage

`default_nettype none

module jacobian_top import arm_pkg::*, sched_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   en,
	input  angle_t theta1,
	input  angle_t theta2,
	output fix_t   j11,
	output fix_t   j12,
	output fix_t   j21,
	output fix_t   j22,
	output logic   frame_done
);

	op_e    op;
	angle_t theta1_q;
	angle_t theta12_q;
	fix_t   s1;
	fix_t   c1;
	fix_t   s12;
	fix_t   c12;
	fix_t   acc_j11;
	fix_t   acc_j12;
	fix_t   acc_j21;
	fix_t   acc_j22;

	jacobian_sequencer u_seq (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (en),
		.op    (op)
	);

	joint_capture u_capture (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.op        (op),
		.theta1    (theta1),
		.theta2    (theta2),
		.theta1_q  (theta1_q),
		.theta12_q (theta12_q)
	);

	sincos_unit u_trig (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.op        (op),
		.theta1_q  (theta1_q),
		.theta12_q (theta12_q),
		.s1        (s1),
		.c1        (c1),
		.s12       (s12),
		.c12       (c12)
	);

	jacobian_mac u_mac (
		.clk     (clk),
		.rst_n   (rst_n),
		.en      (en),
		.op      (op),
		.s1      (s1),
		.c1      (c1),
		.s12     (s12),
		.c12     (c12),
		.acc_j11 (acc_j11),
		.acc_j12 (acc_j12),
		.acc_j21 (acc_j21),
		.acc_j22 (acc_j22)
	);

	jacobian_out u_out (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.op         (op),
		.acc_j11    (acc_j11),
		.acc_j12    (acc_j12),
		.acc_j21    (acc_j21),
		.acc_j22    (acc_j22),
		.j11        (j11),
		.j12        (j12),
		.j21        (j21),
		.j22        (j22),
		.frame_done (frame_done)
	);

endmodule

`default_nettype wire

// File: verilog/joint_capture.sv
// joint angle capture, samples both encoders once per frame
// removes the zero offsets and forms the summed angle theta12

`default_nettype none

module joint_capture import arm_pkg::*, sched_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   en,
	input  op_e    op,
	input  angle_t theta1,
	input  angle_t theta2,
	output angle_t theta1_q,
	output angle_t theta12_q
);

	angle_t theta1_rel;
	angle_t theta2_rel;

	assign theta1_rel = theta1 - JOINT1_OFFSET;   // wraps mod 4096
	assign theta2_rel = theta2 - JOINT2_OFFSET;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			theta1_q  <= '0;
			theta12_q <= '0;
		end else if (en && op == OP_CAPTURE) begin
			theta1_q  <= theta1_rel;
			theta12_q <= theta1_rel + theta2_rel;    // held until next capture
		end
	end

endmodule

`default_nettype wire

// File: verilog/sched_pkg.sv
// frame schedule for the Jacobian engine
// one opcode per enabled cycle, twelve cycles per frame

`default_nettype none

package sched_pkg;

	localparam int FRAME_LEN = 12;         // enabled cycles per frame

	typedef logic [3:0] count_t;

	typedef enum logic [3:0] {
		OP_CAPTURE,                        // sample joint angles
		OP_TRIG1,                          // sin/cos of theta1
		OP_TRIG12,                         // sin/cos of theta1 + theta2
		OP_MUL_S1,
		OP_MAC_S12,
		OP_MUL_S12,
		OP_MUL_C1,
		OP_MAC_C12,
		OP_MUL_C12,
		OP_PUBLISH,                        // copy entries to the outputs
		OP_IDLE
	} op_e;

endpackage

`default_nettype wire

// File: verilog/sincos_unit.sv
// sine and cosine unit, quarter-wave table lookup with quadrant folding
// keeps the sin/cos pair of theta1 and of theta12 for the whole frame

`default_nettype none

module sincos_unit import arm_pkg::*, sched_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   en,
	input  op_e    op,
	input  angle_t theta1_q,
	input  angle_t theta12_q,
	output fix_t   s1,
	output fix_t   c1,
	output fix_t   s12,
	output fix_t   c12
);

	`include "sine_table.svh"

	angle_t angle_sel;
	angle_t angle_cos;
	fix_t   sin_val;
	fix_t   cos_val;

	// quadrant in bits 11:10, table step in bits 9:5
	function automatic fix_t sine_lookup(input angle_t a);
		logic [1:0] quad;
		logic [4:0] pos;
		fix_t       mag;
		quad = a[11:10];
		pos  = a[9:5];
		mag  = quad[0] ? SINE_TABLE[TABLE_STEPS - pos] : SINE_TABLE[pos];   // mirror in q1, q3
		return quad[1] ? -mag : mag;                                        // negative half turn
	endfunction

	assign angle_sel = (op == OP_TRIG12) ? theta12_q : theta1_q;
	assign angle_cos = angle_sel + 12'd1024;         // cos(a) = sin(a + quarter turn)
	assign sin_val   = sine_lookup(angle_sel);
	assign cos_val   = sine_lookup(angle_cos);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1  <= '0;
			c1  <= '0;
			s12 <= '0;
			c12 <= '0;
		end else if (en) begin
			if (op == OP_TRIG1) begin
				s1 <= sin_val;
				c1 <= cos_val;
			end else if (op == OP_TRIG12) begin
				s12 <= sin_val;
				c12 <= cos_val;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/sine_table.svh
// quarter-wave sine table, 33 points over 0..pi/2 in Q1.14
// included inside a module body, entry k is round(16384*sin(k*pi/64))

localparam logic signed [15:0] SINE_TABLE [0:32] = '{
	16'sd0,
	16'sd804,
	16'sd1606,
	16'sd2404,
	16'sd3196,
	16'sd3981,
	16'sd4756,
	16'sd5520,
	16'sd6270,
	16'sd7005,
	16'sd7723,
	16'sd8423,
	16'sd9102,
	16'sd9760,
	16'sd10394,
	16'sd11003,
	16'sd11585,
	16'sd12140,
	16'sd12665,
	16'sd13160,
	16'sd13623,
	16'sd14053,
	16'sd14449,
	16'sd14811,
	16'sd15137,
	16'sd15426,
	16'sd15679,
	16'sd15893,
	16'sd16069,
	16'sd16207,
	16'sd16305,
	16'sd16364,
	16'sd16384                             // sin(pi/2), needs the full Q1.14 range
};
